// File: ntrpt_fifo_top.f
src/ntrpt_fifo_cfg_pkg.sv
src/ntrpt_entry_pkg.sv
src/fifo_occupancy.sv
src/entry_shift_array.sv
src/entry_scan.sv
src/ntrpt_fifo_top.sv
bench/ntrpt_fifo_chk.sv
bench/ntrpt_fifo_tb.sv

// File: Bender.yml
package:
  name: ntrpt_fifo

sources:
  # Packages first, then the RTL blocks and the top level
  - src/ntrpt_fifo_cfg_pkg.sv
  - src/ntrpt_entry_pkg.sv
  - src/fifo_occupancy.sv
  - src/entry_shift_array.sv
  - src/entry_scan.sv
  - src/ntrpt_fifo_top.sv

  # Simulation only
  - target: test
    files:
      - bench/ntrpt_fifo_chk.sv
      - bench/ntrpt_fifo_tb.sv

// File: bench/ntrpt_fifo_tb.sv
// Testbench for the interrupt-request queue
// Reference queue model, directed tests and the closing summary

`timescale 1ns/1ps
`default_nettype none

module ntrpt_fifo_tb;

  import ntrpt_fifo_cfg_pkg::*;
  import ntrpt_entry_pkg::*;

  logic                   clk;
  logic                   reset;
  logic                   push;
  logic                   pop;
  logic [entry_width-1:0] data_in;
  logic [entry_width-1:0] data_out;
  logic                   pndng;
  logic                   full;
  logic                   mtip;

  // Reference queue, oldest word at index 0
  logic [entry_width-1:0] model_q [$];

  int check_count;
  int mismatch_count;
  int timeout_count;

  ntrpt_fifo_top i_dut (
    .clk      (clk),
    .reset    (reset),
    .push     (push),
    .pop      (pop),
    .data_in  (data_in),
    .data_out (data_out),
    .pndng    (pndng),
    .full     (full),
    .mtip     (mtip)
  );

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  ////////////////////
  // Helpers
  ////////////////////

  task automatic compare(input string test_name, input string signal_name,
                         input logic [entry_width-1:0] expected,
                         input logic [entry_width-1:0] actual);
    check_count++;
    if (actual !== expected) begin
      mismatch_count++;
      $display("MISMATCH %s %s: expected %h, actual %h",
               test_name, signal_name, expected, actual);
    end
  endtask

  // Words that never carry the timer cause code
  function automatic logic [entry_width-1:0] random_word();
    logic [entry_width-1:0] w;
    w = $urandom;
    if (w[cause_width-1:0] == mtip_cause) begin
      w[0] = ~w[0];
    end
    return w;
  endfunction

  // Pop frees a slot first, so a push on a full queue fits with it
  task automatic model_step(input logic p, input logic o, input logic [entry_width-1:0] d);
    logic pop_ok;
    logic push_ok;
    pop_ok  = o && (model_q.size() != 0);
    push_ok = p && ((model_q.size() < fifo_depth) || o);
    if (pop_ok) begin
      void'(model_q.pop_front());
    end
    if (push_ok) begin
      model_q.push_back(d);
    end
  endtask

  // One strobe cycle, sampled by the DUT at the second edge
  task automatic drive_cycle(input logic p, input logic o, input logic [entry_width-1:0] d);
    @(posedge clk);
    push    <= p;
    pop     <= o;
    data_in <= d;
    @(posedge clk);
    push <= 1'b0;
    pop  <= 1'b0;
    model_step(p, o, d);
  endtask

  task automatic check_outputs(input string test_name);
    logic [entry_width-1:0] exp_head;
    logic                   exp_mtip;
    @(negedge clk);
    exp_head = (model_q.size() != 0) ? model_q[0] : '0;
    exp_mtip = 1'b0;
    foreach (model_q[i]) begin
      if (model_q[i][cause_width-1:0] == mtip_cause) begin
        exp_mtip = 1'b1;
      end
    end
    compare(test_name, "data_out", exp_head, data_out);
    compare(test_name, "pndng", model_q.size() != 0, pndng);
    compare(test_name, "full", model_q.size() == fifo_depth, full);
    compare(test_name, "mtip", exp_mtip, mtip);
  endtask

  task automatic wait_for_pndng(input string test_name, input logic level,
                                input int max_cycles);
    int cycles;
    cycles = 0;
    do begin
      @(negedge clk);
      cycles++;
    end while (pndng !== level && cycles < max_cycles);
    if (pndng !== level) begin
      timeout_count++;
      $display("ERROR %s: pndng did not go to %b within %0d cycles",
               test_name, level, max_cycles);
    end
  endtask

  task automatic drain_queue(input string test_name);
    while (model_q.size() != 0) begin
      check_outputs(test_name);
      drive_cycle(1'b0, 1'b1, '0);
    end
    check_outputs(test_name);
  endtask

  ////////////////////
  // Directed tests
  ////////////////////

  task automatic test_reset();
    check_outputs("reset");
  endtask

  task automatic test_order();
    logic [entry_width-1:0] words [5];
    foreach (words[i]) begin
      words[i] = random_word();
      drive_cycle(1'b1, 1'b0, words[i]);
      if (i == 0) begin
        wait_for_pndng("order", 1'b1, 4);
      end
      check_outputs("order");
    end
    // Head is read one cycle ahead of its pop
    foreach (words[i]) begin
      check_outputs("order");
      compare("order", "head", words[i], data_out);
      drive_cycle(1'b0, 1'b1, '0);
    end
    wait_for_pndng("order", 1'b0, 4);
    check_outputs("order");
  endtask

  task automatic test_full();
    logic [entry_width-1:0] words [fifo_depth];
    foreach (words[i]) begin
      words[i] = random_word();
      drive_cycle(1'b1, 1'b0, words[i]);
    end
    check_outputs("full");
    // Excess push alone is dropped
    drive_cycle(1'b1, 1'b0, random_word());
    check_outputs("full");
    foreach (words[i]) begin
      check_outputs("full");
      compare("full", "head", words[i], data_out);
      drive_cycle(1'b0, 1'b1, '0);
    end
    check_outputs("full");
  endtask

  task automatic test_push_pop();
    logic [entry_width-1:0] words [3];
    foreach (words[i]) begin
      words[i] = random_word();
      drive_cycle(1'b1, 1'b0, words[i]);
    end
    check_outputs("push_pop");
    drive_cycle(1'b1, 1'b1, random_word());
    check_outputs("push_pop");
    compare("push_pop", "head", words[1], data_out);
    drain_queue("push_pop");
  endtask

  task automatic test_empty_pop();
    logic [entry_width-1:0] w;
    drive_cycle(1'b0, 1'b1, '0);
    check_outputs("empty_pop");
    w = random_word();
    drive_cycle(1'b1, 1'b0, w);
    check_outputs("empty_pop");
    compare("empty_pop", "head", w, data_out);
    drain_queue("empty_pop");
  endtask

  task automatic test_mtip();
    logic [entry_width-1:0] timer_word;
    timer_word = $urandom;
    timer_word[cause_width-1:0] = mtip_cause;
    drive_cycle(1'b1, 1'b0, random_word());
    check_outputs("mtip");
    drive_cycle(1'b1, 1'b0, timer_word);
    check_outputs("mtip");
    drive_cycle(1'b1, 1'b0, random_word());
    check_outputs("mtip");
    compare("mtip", "mtip_queued", 1'b1, mtip);
    drive_cycle(1'b0, 1'b1, '0);
    check_outputs("mtip");
    // Timer word leaves and its stale copy stays above the count
    drive_cycle(1'b0, 1'b1, '0);
    check_outputs("mtip");
    compare("mtip", "mtip_popped", 1'b0, mtip);
    drain_queue("mtip");
  endtask

  ////////////////////
  // Main sequence
  ////////////////////

  initial begin
    check_count    = 0;
    mismatch_count = 0;
    timeout_count  = 0;
    reset          = 1'b1;
    push           = 1'b0;
    pop            = 1'b0;
    data_in        = '0;
    void'($urandom(32'h50b9_c993));
    repeat (4) @(posedge clk);
    reset <= 1'b0;

    test_reset();
    test_order();
    test_full();
    test_push_pop();
    test_empty_pop();
    test_mtip();

    $display("Summary: %0d checks, %0d mismatches, %0d timeouts",
             check_count, mismatch_count, timeout_count);
    if (mismatch_count == 0 && timeout_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule : ntrpt_fifo_tb

`default_nettype wire

// File: bench/ntrpt_fifo_chk.sv
// Assertion checker bound to the queue top level
// Flag consistency and post-reset state

`timescale 1ns/1ps
`default_nettype none

module ntrpt_fifo_chk (
  input logic                                     clk,
  input logic                                     reset,
  input logic [ntrpt_fifo_cfg_pkg::entry_width-1:0] data_out,
  input logic                                     pndng,
  input logic                                     full,
  input logic                                     mtip
);

  ////////////////////
  // Flag consistency
  ////////////////////

  // A visible head word means the queue is not empty
  a_head_needs_pndng : assert property (
    @(posedge clk) disable iff (reset) (data_out != '0) |-> (pndng || full)
  ) else $error("data_out is non-zero while pndng and full are both low");

  a_full_needs_pndng : assert property (
    @(posedge clk) disable iff (reset) full |-> pndng
  ) else $error("full is high while pndng is low");

  a_mtip_needs_pndng : assert property (
    @(posedge clk) disable iff (reset) mtip |-> pndng
  ) else $error("mtip is high while pndng is low");

  ////////////////////
  // Reset state
  ////////////////////

  a_reset_clears : assert property (
    @(posedge clk) $fell(reset) |-> (!pndng && !full && !mtip && data_out == '0)
  ) else $error("outputs not cleared when reset was released");

endmodule : ntrpt_fifo_chk

bind ntrpt_fifo_top ntrpt_fifo_chk i_chk (
  .clk      (clk),
  .reset    (reset),
  .data_out (data_out),
  .pndng    (pndng),
  .full     (full),
  .mtip     (mtip)
);

`default_nettype wire

// File: src/ntrpt_fifo_top.sv
// Top level of the interrupt-request queue
// Plain ports, occupancy control, shift storage and head scan

`timescale 1ns/1ps
`default_nettype none

module ntrpt_fifo_top (
  input  logic                                   clk,
  input  logic                                   reset,
  input  logic                                   push,
  input  logic                                   pop,
  input  logic [ntrpt_fifo_cfg_pkg::entry_width-1:0] data_in,
  output logic [ntrpt_fifo_cfg_pkg::entry_width-1:0] data_out,
  output logic                                   pndng,
  output logic                                   full,
  output logic                                   mtip
);

  import ntrpt_fifo_cfg_pkg::*;
  import ntrpt_entry_pkg::*;

  // Control between occupancy and storage
  logic         shift_en;
  fifo_count_t  count;

  // Stored words and the boundary views of the data ports
  ntrpt_entry_t entries [fifo_depth];
  ntrpt_entry_t data_in_entry;
  ntrpt_entry_t data_out_entry;

  ////////////////////
  // Port conversion
  ////////////////////

  assign data_in_entry.raw = data_in;
  assign data_out          = data_out_entry.raw;

  ////////////////////
  // Occupancy
  ////////////////////

  fifo_occupancy i_occupancy (
    .clk      (clk),
    .reset    (reset),
    .push     (push),
    .pop      (pop),
    .shift_en (shift_en),
    .count    (count),
    .pndng    (pndng),
    .full     (full)
  );

  ////////////////////
  // Storage
  ////////////////////

  entry_shift_array i_storage (
    .clk      (clk),
    .reset    (reset),
    .shift_en (shift_en),
    .data_in  (data_in_entry),
    .entries  (entries)
  );

  ////////////////////
  // Head and match
  ////////////////////

  // Purely combinational so it follows count and entries in the same cycle
  entry_scan i_scan (
    .count    (count),
    .entries  (entries),
    .data_out (data_out_entry),
    .mtip     (mtip)
  );

endmodule : ntrpt_fifo_top

`default_nettype wire

// File: src/entry_scan.sv
// Head selection and machine-timer match over the stored entries
// AND-OR head mux keyed on the count, valid-masked cause compare

`timescale 1ns/1ps
`default_nettype none

module entry_scan (
  input  ntrpt_fifo_cfg_pkg::fifo_count_t count,
  input  ntrpt_entry_pkg::ntrpt_entry_t   entries [ntrpt_fifo_cfg_pkg::fifo_depth],
  output ntrpt_entry_pkg::ntrpt_entry_t   data_out,
  output logic                            mtip
);

  import ntrpt_fifo_cfg_pkg::*;
  import ntrpt_entry_pkg::*;

  // Per-entry decode
  logic [fifo_depth-1:0]  is_head;
  logic [fifo_depth-1:0]  is_valid;
  logic [fifo_depth-1:0]  is_mtip;

  // Masked words and the OR chain that merges them
  logic [entry_width-1:0] head_term [fifo_depth];
  logic [entry_width-1:0] or_chain  [fifo_depth];

  ////////////////////
  // Per-entry terms
  ////////////////////

  for (genvar i = 0; i < fifo_depth; i++) begin : g_entry

    // Oldest valid entry sits at count-1
    assign is_head[i] = (count == fifo_count_t'(i + 1));

    // Entries below the count hold live requests
    assign is_valid[i] = (count > fifo_count_t'(i));

    // Only the head passes, the rest are forced to zero
    assign head_term[i] = entries[i].raw & {entry_width{is_head[i]}};

    // Stale words above the count must not raise the interrupt
    assign is_mtip[i] = is_valid[i] & (entries[i].fields.cause == mtip_cause);

  end : g_entry

  ////////////////////
  // Head OR tree
  ////////////////////

  // Chain runs from the oldest slot down to slot 0
  assign or_chain[fifo_depth-1] = head_term[fifo_depth-1];

  for (genvar i = 0; i < fifo_depth - 1; i++) begin : g_or
    assign or_chain[i] = head_term[i] | or_chain[i+1];
  end : g_or

  // No head selected when empty, so the output reads zero
  assign data_out.raw = or_chain[0];

  ////////////////////
  // Interrupt output
  ////////////////////

  assign mtip = |is_mtip;

endmodule : entry_scan

`default_nettype wire

// File: src/entry_shift_array.sv
// Flip-flop storage of the interrupt-request queue
// Shift register of entries, youngest at index 0

`timescale 1ns/1ps
`default_nettype none

module entry_shift_array (
  input  logic                        clk,
  input  logic                        reset,
  input  logic                        shift_en,
  input  ntrpt_entry_pkg::ntrpt_entry_t data_in,
  output ntrpt_entry_pkg::ntrpt_entry_t entries [ntrpt_fifo_cfg_pkg::fifo_depth]
);

  import ntrpt_fifo_cfg_pkg::*;
  import ntrpt_entry_pkg::*;

  // Value each stage loads on a shift
  ntrpt_entry_t stage_in [fifo_depth];

  ////////////////////
  // Stage chain
  ////////////////////

  for (genvar i = 0; i < fifo_depth; i++) begin : g_stage

    if (i == 0) begin : g_youngest
      // New word enters at the young end
      assign stage_in[i] = data_in;
    end else begin : g_older
      // Everything else moves one place toward the old end
      assign stage_in[i] = entries[i-1];
    end

    // The oldest stage simply falls off on a shift,
    // which only happens then if that word is popped as well
    always_ff @(posedge clk or posedge reset) begin
      if (reset) begin
        entries[i] <= '0;
      end else if (shift_en) begin
        entries[i] <= stage_in[i];
      end
    end

  end : g_stage

endmodule : entry_shift_array

`default_nettype wire

// File: src/fifo_occupancy.sv
// Push and pop acceptance for the interrupt-request queue
// Saturating occupancy count with pending and full decode

`timescale 1ns/1ps
`default_nettype none

module fifo_occupancy (
  input  logic                            clk,
  input  logic                            reset,
  input  logic                            push,
  input  logic                            pop,
  output logic                            shift_en,
  output ntrpt_fifo_cfg_pkg::fifo_count_t count,
  output logic                            pndng,
  output logic                            full
);

  import ntrpt_fifo_cfg_pkg::*;

  logic        empty;
  logic        push_ok;
  logic        pop_ok;
  fifo_count_t count_next;

  ////////////////////
  // Status decode
  ////////////////////

  // Both flags come straight from the registered count
  assign empty = (count == '0);
  assign full  = (count == fifo_count_t'(fifo_depth));
  assign pndng = ~empty;

  ////////////////////
  // Acceptance
  ////////////////////

  // A full queue still takes a push when a pop frees the oldest slot
  assign push_ok = push & (~full | pop);

  // Pop on an empty queue is dropped
  assign pop_ok = pop & ~empty;

  // Every accepted push shifts the storage by one place
  assign shift_en = push_ok;

  ////////////////////
  // Occupancy count
  ////////////////////

  always_comb begin
    case ({push_ok, pop_ok})
      2'b10: begin
        count_next = count + 1'b1;
      end
      2'b01: begin
        count_next = count - 1'b1;
      end
      default: begin
        // Idle, or push and pop cancel out
        count_next = count;
      end
    endcase
  end

  always_ff @(posedge clk or posedge reset) begin
    if (reset) begin
      count <= '0;
    end else begin
      count <= count_next;
    end
  end

endmodule : fifo_occupancy

`default_nettype wire

// File: src/ntrpt_entry_pkg.sv
// Layout of one interrupt-request word
// Entry union with raw and field views, machine-timer cause code

`default_nettype none

package ntrpt_entry_pkg;

  ////////////////////
  // Field widths
  ////////////////////

  // Low half of the word carries the cause code
  localparam int cause_width = 16;

  // Remaining upper bits carry extra request info
  localparam int info_width = ntrpt_fifo_cfg_pkg::entry_width - cause_width;

  // Machine-timer interrupt cause
  localparam logic [cause_width-1:0] mtip_cause = 16'h0080;

  ////////////////////
  // Entry word
  ////////////////////

  // Decoded view with info on top and cause in the low half
  typedef struct packed {
    logic [info_width-1:0]  info;
    logic [cause_width-1:0] cause;
  } ntrpt_fields_t;

  // Same word seen whole for storage or split for the cause match
  typedef union packed {
    logic [ntrpt_fifo_cfg_pkg::entry_width-1:0] raw;
    ntrpt_fields_t                              fields;
  } ntrpt_entry_t;

endpackage : ntrpt_entry_pkg

`default_nettype wire

// File: src/ntrpt_fifo_cfg_pkg.sv
// Geometry of the interrupt-request queue
// Depth, entry width and the occupancy count type

`default_nettype none

package ntrpt_fifo_cfg_pkg;

  ////////////////////
  // Queue geometry
  ////////////////////

  // Number of entries held by the shift array
  localparam int fifo_depth = 16;

  // Width of one queued interrupt word
  localparam int entry_width = 32;

  // One extra bit so the count can reach fifo_depth itself
  localparam int count_width = $clog2(fifo_depth) + 1;

  ////////////////////
  // Count type
  ////////////////////

  // Occupancy runs from 0 (empty) up to fifo_depth (full)
  typedef logic [count_width-1:0] fifo_count_t;

endpackage : ntrpt_fifo_cfg_pkg

`default_nettype wire
